//--- gb_bus_cycle.sv
`timescale 1ns/1ps

module gb_bus_cycle import gb_cpu_pkg::*; #(
    parameter int ADDR_W = ADDR_W_DEF
) (
    input  logic              clk,
    input  logic              rst,
    input  bus_op_t           op,
    input  logic [ADDR_W-1:0] addr,
    input  logic [DATA_W-1:0] wdata,
    input  logic              high_mask,
    input  logic [DATA_W-1:0] din,
    output ct_t               ct,
    output bus_op_t           cur_op,
    output logic              phi,
    output logic [ADDR_W-1:0] a,
    output logic [ADDR_W-1:0] a_early,
    output logic              rd,
    output logic              wr,
    output logic [DATA_W-1:0] dout,
    output logic [DATA_W-1:0] opcode,
    output logic [DATA_W-1:0] rdata,
    output logic              data_valid
);

    ct_t               ct_q;
    bus_op_t           op_q;      // Operation of the current machine cycle
    logic [DATA_W-1:0] wdata_q;

    ////////////////////////////////////////
    // T-cycle counter
    ////////////////////////////////////////

    // Free running, wraps every four clocks
    always_ff @(posedge clk) begin
        if (rst) begin
            ct_q <= CT_ADDR;
        end else begin
            ct_q <= ct_t'(ct_q + 2'd1);
        end
    end

    assign ct     = ct_q;
    assign cur_op = op_q;

    // Phase clock, high across strobe and data
    always_ff @(posedge clk) begin
        if (rst) begin
            phi <= 1'b1;
        end else if (ct_q == CT_ADDR) begin
            phi <= 1'b1;
        end else if (ct_q == CT_DATA) begin
            phi <= 1'b0;
        end
    end

    ////////////////////////////////////////
    // Address setup
    ////////////////////////////////////////

    // High page forces the upper byte, low byte passes
    always_comb begin
        if (high_mask) begin
            a_early = {HIGH_PAGE, addr[ADDR_W-9:0]};
        end else begin
            a_early = addr;
        end
    end

    // Request latched at the end of CT_ADDR
    always_ff @(posedge clk) begin
        if (rst) begin
            op_q <= BUS_IDLE;
            a    <= '0;
        end else if (ct_q == CT_ADDR) begin
            op_q <= op;
            a    <= a_early;
        end
    end

    always_ff @(posedge clk) begin
        if (ct_q == CT_ADDR) begin
            wdata_q <= wdata;  // Held until the write window opens
        end
    end

    ////////////////////////////////////////
    // Read strobe and capture
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            rd         <= 1'b0;
            opcode     <= '0;
            rdata      <= '0;
            data_valid <= 1'b0;
        end else begin
            case (ct_q)
                CT_ADDR: begin
                    rd <= is_read_op(op);  // Strobe and data T-cycles
                end
                CT_DATA: begin
                    rd         <= 1'b0;
                    data_valid <= is_read_op(op_q);
                    if (op_q == BUS_FETCH) begin
                        opcode <= din;
                    end else if (op_q == BUS_READ) begin
                        rdata <= din;
                    end
                end
                CT_IDLE: begin
                    data_valid <= 1'b0;  // One clock only
                end
                default: begin
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // Write strobe and data
    ////////////////////////////////////////

    // wr and dout cover CT_DATA and CT_IDLE
    always_ff @(posedge clk) begin
        if (rst) begin
            wr   <= 1'b0;
            dout <= '0;
        end else begin
            if (ct_q == CT_STROBE && op_q == BUS_WRITE) begin
                wr   <= 1'b1;
                dout <= wdata_q;
            end else if (ct_q == CT_IDLE) begin
                wr   <= 1'b0;
                dout <= '0;       // Bus released
            end
        end
    end

endmodule

//--- gb_cpu_pkg.sv
package gb_cpu_pkg;

    ////////////////////////////////////////
    // Bus operations
    ////////////////////////////////////////

    // One requested bus operation per machine cycle
    typedef enum logic [1:0] {
        BUS_IDLE  = 2'b00,
        BUS_FETCH = 2'b01,  // Opcode fetch
        BUS_WRITE = 2'b10,
        BUS_READ  = 2'b11   // Data read
    } bus_op_t;

    // T-cycle index inside a machine cycle
    typedef enum logic [1:0] {
        CT_ADDR   = 2'b00,  // Address setup
        CT_STROBE = 2'b01,
        CT_DATA   = 2'b10,  // Read data sampled at the end
        CT_IDLE   = 2'b11
    } ct_t;

    ////////////////////////////////////////
    // Widths and constants
    ////////////////////////////////////////

    localparam int ADDR_W_DEF    = 16;
    localparam int DATA_W        = 8;
    localparam int INT_COUNT_DEF = 5;   // VBlank, LCD, timer, serial, joypad

    // Interrupt vectors
    localparam logic [15:0] INT_VEC_BASE = 16'h0040;
    localparam logic [15:0] INT_VEC_STEP = 16'd8;
    localparam logic [15:0] INT_VEC_NONE = 16'h0000;  // Dispatch cancelled

    // Upper address byte for the FF00 page
    localparam logic [7:0] HIGH_PAGE = 8'hFF;

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    // Operations that drive rd and return a byte
    function automatic logic is_read_op(input bus_op_t op);
        logic result;
        result = (op == BUS_FETCH) || (op == BUS_READ);
        return result;
    endfunction

endpackage

//--- gb_int_ctrl.sv
`timescale 1ns/1ps

module gb_int_ctrl import gb_cpu_pkg::*; #(
    parameter int INT_COUNT = INT_COUNT_DEF
) (
    input  logic                 clk,
    input  logic                 rst,
    input  ct_t                  ct,
    input  bus_op_t              cur_op,
    input  logic                 ime,
    input  logic                 int_ack,
    input  logic                 halt,
    input  logic                 stop,
    input  logic [INT_COUNT-1:0] int_en,
    input  logic [INT_COUNT-1:0] int_flags_in,
    input  logic [DATA_W-1:0]    key_in,
    output logic                 int_dispatch,
    output logic [15:0]          int_vector,
    output logic [INT_COUNT-1:0] int_flags_out,
    output logic                 wake,
    output logic                 done
);

    localparam int IDX_W = (INT_COUNT > 1) ? $clog2(INT_COUNT) : 1;

    logic [INT_COUNT-1:0] int_req;      // Requested and enabled
    logic [INT_COUNT-1:0] int_pending;  // Also gated by ime
    logic [INT_COUNT-1:0] top_onehot;
    logic [INT_COUNT-1:0] flags_cleared;
    logic [IDX_W-1:0]     top_idx;
    logic                 top_valid;
    logic                 wake_cond;
    logic                 wake_q;

    ////////////////////////////////////////
    // Priority and vector
    ////////////////////////////////////////

    assign int_req     = int_flags_in & int_en;
    assign int_pending = int_req & {INT_COUNT{ime}};

    // Lowest set bit only
    assign top_onehot    = int_pending & (~int_pending + 1'b1);
    assign flags_cleared = int_flags_in & ~top_onehot;

    // Scan from the top so the lowest index wins
    always_comb begin
        top_idx   = '0;
        top_valid = 1'b0;
        for (int i = INT_COUNT - 1; i >= 0; i--) begin
            if (int_pending[i]) begin
                top_idx   = IDX_W'(i);
                top_valid = 1'b1;
            end
        end
    end

    always_comb begin
        if (top_valid) begin
            int_vector = INT_VEC_BASE + INT_VEC_STEP * 16'(top_idx);
        end else begin
            int_vector = INT_VEC_NONE;  // Nothing left, jump to zero
        end
    end

    // Serviced bit cleared only during the acknowledge
    always_comb begin
        if (int_dispatch && int_ack) begin
            int_flags_out = flags_cleared;
        end else begin
            int_flags_out = int_flags_in;
        end
    end

    ////////////////////////////////////////
    // Dispatch flag
    ////////////////////////////////////////

    // Taken at an instruction boundary or while halted
    always_ff @(posedge clk) begin
        if (rst) begin
            int_dispatch <= 1'b0;
        end else if (ct == CT_DATA) begin
            if (!int_dispatch && top_valid && (cur_op == BUS_FETCH || halt)) begin
                int_dispatch <= 1'b1;
            end else if (int_dispatch && int_ack) begin
                int_dispatch <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // Wake and done
    ////////////////////////////////////////

    // ime is ignored for wake-up
    always_comb begin
        if (halt) begin
            wake_cond = |int_req;
        end else if (stop) begin
            wake_cond = (|int_req) || (key_in != '0);  // Keypad also wakes STOP
        end else begin
            wake_cond = 1'b0;
        end
    end

    // Two stages, one machine cycle of extra delay
    always_ff @(posedge clk) begin
        if (rst) begin
            wake_q <= 1'b0;
            wake   <= 1'b0;
        end else if (ct == CT_DATA) begin
            wake_q <= wake_cond;
            wake   <= wake_q;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            done <= 1'b0;
        end else begin
            done <= halt | stop;  // One clock behind
        end
    end

endmodule

//--- gb_mcycle_top.f
gb_cpu_pkg.sv
gb_bus_cycle.sv
gb_int_ctrl.sv
gb_mcycle_top.sv
tb_gb_checker.sv
tb_gb_mcycle_sva.sv
tb_gb_mcycle.sv

//--- gb_mcycle_top.sv
`timescale 1ns/1ps

module gb_mcycle_top import gb_cpu_pkg::*; #(
    parameter int ADDR_W    = ADDR_W_DEF,
    parameter int INT_COUNT = INT_COUNT_DEF
) (
    input  logic                 clk,
    input  logic                 rst,

    // Bus request for the next machine cycle
    input  bus_op_t              op,
    input  logic [ADDR_W-1:0]    addr,
    input  logic [DATA_W-1:0]    wdata,
    input  logic                 high_mask,

    // External bus
    input  logic [DATA_W-1:0]    din,
    output ct_t                  ct,
    output logic                 phi,
    output logic [ADDR_W-1:0]    a,
    output logic [ADDR_W-1:0]    a_early,
    output logic                 rd,
    output logic                 wr,
    output logic [DATA_W-1:0]    dout,

    // Captured data
    output logic [DATA_W-1:0]    opcode,
    output logic [DATA_W-1:0]    rdata,
    output logic                 data_valid,

    // Interrupts and low power
    input  logic                 ime,
    input  logic                 int_ack,
    input  logic                 halt,
    input  logic                 stop,
    input  logic [INT_COUNT-1:0] int_en,
    input  logic [INT_COUNT-1:0] int_flags_in,
    input  logic [DATA_W-1:0]    key_in,
    output logic                 int_dispatch,
    output logic [15:0]          int_vector,
    output logic [INT_COUNT-1:0] int_flags_out,
    output logic                 wake,
    output logic                 done
);

    bus_op_t cur_op;  // Operation in flight, for the dispatch check

    ////////////////////////////////////////
    // Bus cycle sequencer
    ////////////////////////////////////////

    gb_bus_cycle #(
        .ADDR_W(ADDR_W)
    ) u_bus (
        .clk       (clk),
        .rst       (rst),
        .op        (op),
        .addr      (addr),
        .wdata     (wdata),
        .high_mask (high_mask),
        .din       (din),
        .ct        (ct),
        .cur_op    (cur_op),
        .phi       (phi),
        .a         (a),
        .a_early   (a_early),
        .rd        (rd),
        .wr        (wr),
        .dout      (dout),
        .opcode    (opcode),
        .rdata     (rdata),
        .data_valid(data_valid)
    );

    ////////////////////////////////////////
    // Interrupt and wake control
    ////////////////////////////////////////

    gb_int_ctrl #(
        .INT_COUNT(INT_COUNT)
    ) u_int (
        .clk          (clk),
        .rst          (rst),
        .ct           (ct),
        .cur_op       (cur_op),
        .ime          (ime),
        .int_ack      (int_ack),
        .halt         (halt),
        .stop         (stop),
        .int_en       (int_en),
        .int_flags_in (int_flags_in),
        .key_in       (key_in),
        .int_dispatch (int_dispatch),
        .int_vector   (int_vector),
        .int_flags_out(int_flags_out),
        .wake         (wake),
        .done         (done)
    );

endmodule

//--- run_sim.sh
#!/bin/sh
# Compile with Verilator and run, pass is decided by the printed result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
    -f gb_mcycle_top.f --top-module tb_gb_mcycle -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -qx "sim passed" &&
echo "PASS" ||
{ echo "FAIL"; exit 1; }

//--- tb_gb_checker.sv
`timescale 1ns/1ps

module tb_gb_checker import gb_cpu_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        active,
    input  bus_op_t     exp_op,
    input  logic [15:0] exp_a,
    input  logic [7:0]  exp_wdata,
    input  logic [7:0]  exp_byte,
    input  logic [15:0] exp_vec,
    input  logic [4:0]  exp_flags,
    input  logic        exp_disp,
    input  logic        exp_wake,
    input  logic        exp_done,
    input  ct_t         ct,
    input  logic        phi,
    input  logic [15:0] a,
    input  logic [15:0] a_early,
    input  logic        rd,
    input  logic        wr,
    input  logic [7:0]  dout,
    input  logic [7:0]  opcode,
    input  logic [7:0]  rdata,
    input  logic        data_valid,
    input  logic        int_dispatch,
    input  logic [15:0] int_vector,
    input  logic [4:0]  int_flags_out,
    input  logic        wake,
    input  logic        done,
    output int          error_count,
    output int          check_count
);

    logic       rst_seen = 1'b0;
    logic       done_prev = 1'b0;  // done expected in the previous row
    logic       exp_rd;
    logic       exp_wr;
    logic [7:0] exp_dout;

    assign exp_rd   = (exp_op == BUS_FETCH) || (exp_op == BUS_READ);
    assign exp_wr   = (exp_op == BUS_WRITE);
    assign exp_dout = exp_wr ? exp_wdata : 8'h00;

    initial begin
        error_count = 0;
        check_count = 0;
    end

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            rst_seen <= 1'b1;
        end
    end

    // Sampled on the falling edge
    always @(negedge clk) begin
        if (rst && rst_seen) begin
            compare_value("reset rd/wr/valid", 32'({rd, wr, data_valid}), 32'd0);
            compare_value("reset dispatch/wake/done", 32'({int_dispatch, wake, done}), 32'd0);
            compare_value("reset a", 32'(a), 32'd0);
            compare_value("reset dout/opcode/rdata", 32'({dout, opcode, rdata}), 32'd0);
            compare_value("reset phi", 32'(phi), 32'd1);
        end else if (!rst && active) begin
            case (ct)
                CT_ADDR: begin
                    compare_value("a_early", 32'(a_early), 32'(exp_a));
                    compare_value("phi in CT_ADDR", 32'(phi), 32'd0);
                    compare_value("done in CT_ADDR", 32'(done), 32'(done_prev));  // Not yet updated
                end
                CT_STROBE: begin
                    compare_value("a in CT_STROBE", 32'(a), 32'(exp_a));
                    compare_value("rd in CT_STROBE", 32'(rd), 32'(exp_rd));
                    compare_value("wr in CT_STROBE", 32'(wr), 32'd0);
                    compare_value("dout in CT_STROBE", 32'(dout), 32'd0);
                    compare_value("phi in CT_STROBE", 32'(phi), 32'd1);
                    compare_value("done in CT_STROBE", 32'(done), 32'(exp_done));
                end
                CT_DATA: begin
                    compare_value("a in CT_DATA", 32'(a), 32'(exp_a));
                    compare_value("rd in CT_DATA", 32'(rd), 32'(exp_rd));
                    compare_value("wr in CT_DATA", 32'(wr), 32'(exp_wr));
                    compare_value("dout in CT_DATA", 32'(dout), 32'(exp_dout));
                    compare_value("phi in CT_DATA", 32'(phi), 32'd1);
                    compare_value("int_vector", 32'(int_vector), 32'(exp_vec));
                    compare_value("int_flags_out", 32'(int_flags_out), 32'(exp_flags));
                end
                default: begin  // CT_IDLE
                    compare_value("a in CT_IDLE", 32'(a), 32'(exp_a));
                    compare_value("rd in CT_IDLE", 32'(rd), 32'd0);
                    compare_value("wr in CT_IDLE", 32'(wr), 32'(exp_wr));
                    compare_value("dout in CT_IDLE", 32'(dout), 32'(exp_dout));
                    compare_value("phi in CT_IDLE", 32'(phi), 32'd0);
                    compare_value("data_valid", 32'(data_valid), 32'(exp_rd));
                    if (exp_op == BUS_FETCH) begin
                        compare_value("opcode", 32'(opcode), 32'(exp_byte));
                    end else if (exp_op == BUS_READ) begin
                        compare_value("rdata", 32'(rdata), 32'(exp_byte));
                    end
                    compare_value("int_dispatch", 32'(int_dispatch), 32'(exp_disp));
                    compare_value("wake", 32'(wake), 32'(exp_wake));
                    compare_value("done", 32'(done), 32'(exp_done));
                    done_prev <= exp_done;
                end
            endcase
        end
    end

endmodule

//--- tb_gb_mcycle.sv
`timescale 1ns/1ps

module tb_gb_mcycle import gb_cpu_pkg::*; ;

    typedef struct {
        bus_op_t     op;
        logic [15:0] addr;
        logic [7:0]  wdata;
        logic        high_mask;
        logic        ime;
        logic [4:0]  int_en;
        logic [4:0]  int_flags;
        logic        halt;
        logic        stop;
        logic [7:0]  key;
        logic        ack;
        logic [15:0] exp_a;
        logic [15:0] exp_vec;
        logic [4:0]  exp_flags;
        logic        exp_disp;
        logic        exp_wake;
        logic        exp_done;
    } row_t;

    logic        clk;
    logic        rst;
    bus_op_t     op;
    logic [15:0] addr;
    logic [7:0]  wdata;
    logic        high_mask;
    logic [7:0]  din;
    ct_t         ct;
    logic        phi;
    logic [15:0] a;
    logic [15:0] a_early;
    logic        rd;
    logic        wr;
    logic [7:0]  dout;
    logic [7:0]  opcode;
    logic [7:0]  rdata;
    logic        data_valid;
    logic        ime;
    logic        int_ack;
    logic        halt;
    logic        stop;
    logic [4:0]  int_en;
    logic [4:0]  int_flags_in;
    logic [7:0]  key_in;
    logic        int_dispatch;
    logic [15:0] int_vector;
    logic [4:0]  int_flags_out;
    logic        wake;
    logic        done;

    logic [7:0]  mem [0:65535];
    row_t        rows [$];
    row_t        cur;
    logic        active;
    integer      seed;
    int          timeouts;
    int          error_count;
    int          check_count;

    gb_mcycle_top DUT (.*);

    tb_gb_checker u_chk (
        .clk(clk), .rst(rst), .active(active), .exp_op(cur.op), .exp_a(cur.exp_a),
        .exp_wdata(cur.wdata), .exp_byte(mem[cur.exp_a]), .exp_vec(cur.exp_vec),
        .exp_flags(cur.exp_flags), .exp_disp(cur.exp_disp), .exp_wake(cur.exp_wake),
        .exp_done(cur.exp_done), .ct(ct), .phi(phi), .a(a), .a_early(a_early), .rd(rd),
        .wr(wr), .dout(dout), .opcode(opcode), .rdata(rdata), .data_valid(data_valid),
        .int_dispatch(int_dispatch), .int_vector(int_vector),
        .int_flags_out(int_flags_out), .wake(wake), .done(done),
        .error_count(error_count), .check_count(check_count)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////////////////////////
    // Memory model
    ////////////////////////////////////////

    assign din = mem[a];

    initial begin
        seed = 32'h63599df8;
        for (int i = 0; i < 65536; i++) begin
            mem[i] = 8'($random(seed)) ^ i[7:0] ^ i[15:8];  // Mixes in whole address
        end
        forever begin
            @(posedge clk);
            if (wr) begin
                mem[a] = dout;
            end
        end
    end

    task automatic add_row(input bus_op_t r_op, input logic [15:0] r_addr,
                           input logic [7:0] r_wdata, input logic r_hm, input logic r_ime,
                           input logic [4:0] r_en, input logic [4:0] r_flags,
                           input logic r_halt, input logic r_stop, input logic [7:0] r_key,
                           input logic r_ack, input logic [15:0] e_a,
                           input logic [15:0] e_vec, input logic [4:0] e_flags,
                           input logic e_disp, input logic e_wake, input logic e_done);
        row_t r;
        r = '{r_op, r_addr, r_wdata, r_hm, r_ime, r_en, r_flags, r_halt, r_stop, r_key,
              r_ack, e_a, e_vec, e_flags, e_disp, e_wake, e_done};
        rows.push_back(r);
    endtask

    // Waits for the rising edge that starts CT_ADDR, lands 1 ns after it
    task automatic wait_addr_phase();
        int cycles;
        cycles = 0;
        @(posedge clk);
        #1;
        while (ct != CT_ADDR && cycles < 8) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (ct != CT_ADDR) begin
            timeouts++;
            $display("Timeout at %0t: T-cycle counter never reached CT_ADDR", $time);
        end
    endtask

    task automatic drive_row(input row_t r);
        cur          = r;
        op           = r.op;
        addr         = r.addr;
        wdata        = r.wdata;
        high_mask    = r.high_mask;
        ime          = r.ime;
        int_en       = r.int_en;
        int_flags_in = r.int_flags;
        halt         = r.halt;
        stop         = r.stop;
        key_in       = r.key;
        int_ack      = r.ack;
    endtask

    ////////////////////////////////////////
    // Stimulus table and main sequence
    ////////////////////////////////////////

    initial begin
        rst = 1'b1;
        active = 1'b0;
        timeouts = 0;
        cur = '{BUS_IDLE, 16'h0, 8'h0, 1'b0, 1'b0, 5'h0, 5'h0, 1'b0, 1'b0, 8'h0, 1'b0,
                16'h0, 16'h0, 5'h0, 1'b0, 1'b0, 1'b0};
        drive_row(cur);
        //      op         addr      wd     hm ime en     flags  hlt stp key    ack
        //      exp_a      vec       flags  dsp wak dne
        add_row(BUS_FETCH, 16'h0100, 8'h00, 0, 0, 5'h00, 5'h00, 0, 0, 8'h00, 0,
                16'h0100, 16'h0000, 5'h00, 0, 0, 0);
        add_row(BUS_READ,  16'h0234, 8'h00, 0, 0, 5'h00, 5'h00, 0, 0, 8'h00, 0,
                16'h0234, 16'h0000, 5'h00, 0, 0, 0);
        add_row(BUS_WRITE, 16'h0300, 8'hA5, 0, 0, 5'h00, 5'h00, 0, 0, 8'h00, 0,
                16'h0300, 16'h0000, 5'h00, 0, 0, 0);
        add_row(BUS_READ,  16'h0300, 8'h00, 0, 0, 5'h00, 5'h00, 0, 0, 8'h00, 0,
                16'h0300, 16'h0000, 5'h00, 0, 0, 0);  // Reads back the write
        add_row(BUS_FETCH, 16'h1280, 8'h00, 1, 0, 5'h00, 5'h00, 0, 0, 8'h00, 0,
                16'hFF80, 16'h0000, 5'h00, 0, 0, 0);
        add_row(BUS_READ,  16'hABCD, 8'h00, 1, 0, 5'h00, 5'h00, 0, 0, 8'h00, 0,
                16'hFFCD, 16'h0000, 5'h00, 0, 0, 0);
        add_row(BUS_FETCH, 16'h0400, 8'h00, 0, 0, 5'h1F, 5'h16, 0, 0, 8'h00, 0,
                16'h0400, 16'h0000, 5'h16, 0, 0, 0);  // ime low blocks dispatch
        add_row(BUS_FETCH, 16'h0401, 8'h00, 0, 1, 5'h1F, 5'h16, 0, 0, 8'h00, 0,
                16'h0401, 16'h0048, 5'h16, 1, 0, 0);
        add_row(BUS_READ,  16'h0402, 8'h00, 0, 1, 5'h1F, 5'h16, 0, 0, 8'h00, 1,
                16'h0402, 16'h0048, 5'h14, 0, 0, 0);
        add_row(BUS_READ,  16'h0403, 8'h00, 0, 1, 5'h1C, 5'h16, 0, 0, 8'h00, 0,
                16'h0403, 16'h0050, 5'h16, 0, 0, 0);
        add_row(BUS_IDLE,  16'h0000, 8'h00, 0, 0, 5'h04, 5'h00, 1, 0, 8'h00, 0,
                16'h0000, 16'h0000, 5'h00, 0, 0, 1);
        add_row(BUS_IDLE,  16'h0000, 8'h00, 0, 0, 5'h04, 5'h04, 1, 0, 8'h00, 0,
                16'h0000, 16'h0000, 5'h04, 0, 0, 1);
        add_row(BUS_IDLE,  16'h0000, 8'h00, 0, 0, 5'h04, 5'h04, 1, 0, 8'h00, 0,
                16'h0000, 16'h0000, 5'h04, 0, 1, 1);
        add_row(BUS_IDLE,  16'h0000, 8'h00, 0, 0, 5'h04, 5'h00, 0, 1, 8'h00, 0,
                16'h0000, 16'h0000, 5'h00, 0, 1, 1);
        add_row(BUS_IDLE,  16'h0000, 8'h00, 0, 0, 5'h04, 5'h00, 0, 1, 8'h08, 0,
                16'h0000, 16'h0000, 5'h00, 0, 0, 1);
        add_row(BUS_IDLE,  16'h0000, 8'h00, 0, 0, 5'h00, 5'h00, 0, 0, 8'h00, 0,
                16'h0000, 16'h0000, 5'h00, 0, 1, 0);
        add_row(BUS_IDLE,  16'h0000, 8'h00, 0, 0, 5'h00, 5'h00, 0, 0, 8'h00, 0,
                16'h0000, 16'h0000, 5'h00, 0, 0, 0);
        add_row(BUS_IDLE,  16'h0000, 8'h00, 0, 1, 5'h01, 5'h01, 1, 0, 8'h00, 0,
                16'h0000, 16'h0040, 5'h01, 1, 0, 1);  // Dispatch while halted
        add_row(BUS_IDLE,  16'h0000, 8'h00, 0, 1, 5'h01, 5'h01, 0, 0, 8'h00, 1,
                16'h0000, 16'h0040, 5'h00, 0, 1, 0);
        add_row(BUS_IDLE,  16'h0000, 8'h00, 0, 0, 5'h00, 5'h00, 0, 0, 8'h00, 0,
                16'h0000, 16'h0000, 5'h00, 0, 0, 0);

        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int i = 0; i < rows.size() && timeouts == 0; i++) begin
            wait_addr_phase();
            drive_row(rows[i]);
            active = 1'b1;
        end
        wait_addr_phase();  // Let the last row finish
        active = 1'b0;
        #1;

        $display("checks=%0d errors=%0d timeouts=%0d", check_count, error_count, timeouts);
        if (error_count == 0 && timeouts == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- tb_gb_mcycle_sva.sv
`timescale 1ns/1ps

module tb_gb_mcycle_sva import gb_cpu_pkg::*; (
    input logic clk,
    input logic rst,
    input ct_t  ct,
    input logic rd,
    input logic wr,
    input logic data_valid
);

    ////////////////////////////////////////
    // Strobe windows
    ////////////////////////////////////////

    assert property (@(posedge clk) disable iff (rst) !(rd && wr))
        else $error("rd and wr are high together");

    assert property (@(posedge clk) disable iff (rst) rd |-> (ct == CT_STROBE || ct == CT_DATA))
        else $error("rd is high outside CT_STROBE and CT_DATA");

    assert property (@(posedge clk) disable iff (rst) wr |-> (ct == CT_DATA || ct == CT_IDLE))
        else $error("wr is high outside CT_DATA and CT_IDLE");

    assert property (@(posedge clk) disable iff (rst) data_valid |-> (ct == CT_IDLE))
        else $error("data_valid is high outside CT_IDLE");

endmodule

bind gb_bus_cycle tb_gb_mcycle_sva u_sva (
    .clk(clk), .rst(rst), .ct(ct), .rd(rd), .wr(wr), .data_valid(data_valid)
);
